//--- hdl/cnn_shape_pkg.sv
package cnn_shape_pkg;

	// image and feature dimensions
	localparam int IMG_H = 8;
	localparam int IMG_W = 8;
	localparam int CONV_CH = 2;
	localparam int POOL_W = 4;
	localparam int POOL_ROWS = 4;
	localparam int NUM_CLASSES = 3;
	localparam int KSIZE = 3;

	localparam int PIXEL_W = 8;
	localparam int SCORE_W = 20;
	localparam int FEATURE_MAX = 255;

	// features per pooled row and dense inputs over the whole image
	localparam int FEAT_PER_ROW = POOL_W * CONV_CH;
	localparam int DENSE_IN = POOL_ROWS * FEAT_PER_ROW;

	typedef logic [PIXEL_W-1:0] pixel_t;
	// column c sits at bits [c*8 +: 8]
	typedef logic [IMG_W*PIXEL_W-1:0] pixel_row_t;
	// index 0 and IMG_W+1 are the zero pad pixels
	typedef logic [(IMG_W+2)*PIXEL_W-1:0] padded_row_t;

	typedef struct packed {
		padded_row_t top;
		padded_row_t mid;
		padded_row_t bot;
	} window_t;

	typedef logic [PIXEL_W-1:0] feature_t;
	// feature of column c, channel k at [(c*CONV_CH + k)*8 +: 8]
	typedef logic [IMG_W*CONV_CH*PIXEL_W-1:0] conv_row_t;
	// same layout with POOL_W columns
	typedef logic [POOL_W*CONV_CH*PIXEL_W-1:0] pool_row_t;

	// 3x3 sum plus bias with room for 17 x 255 and a 16-bit bias
	typedef logic signed [17:0] conv_sum_t;

	typedef logic signed [SCORE_W-1:0] score_t;
	typedef logic [1:0] class_t;
	// class j at [j*SCORE_W +: SCORE_W]
	typedef logic [NUM_CLASSES*SCORE_W-1:0] scores_t;

	typedef struct packed {
		class_t class_idx;
		scores_t scores;
	} cnn_result_t;

	typedef logic [$clog2(IMG_H)-1:0] row_idx_t;
	typedef logic [$clog2(POOL_ROWS)-1:0] pool_idx_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCUM,
		DECIDE
	} dense_state_t;

endpackage

//--- hdl/cnn_weight_pkg.sv
package cnn_weight_pkg;

	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] conv_bias_t;

	// kernel[channel][row][col]
	// channel 0 is a Laplacian and channel 1 a blur whose taps sum to 17
	localparam weight_t CONV_KERNEL [cnn_shape_pkg::CONV_CH][cnn_shape_pkg::KSIZE]
		[cnn_shape_pkg::KSIZE] = '{
		'{'{-8'sd1, -8'sd1, -8'sd1}, '{-8'sd1, 8'sd8, -8'sd1}, '{-8'sd1, -8'sd1, -8'sd1}},
		'{'{8'sd1, 8'sd2, 8'sd1}, '{8'sd2, 8'sd5, 8'sd2}, '{8'sd1, 8'sd2, 8'sd1}}
	};

	localparam conv_bias_t CONV_BIAS [cnn_shape_pkg::CONV_CH] = '{16'sd24, -16'sd40};

	// requantization before the 0..255 clamp
	localparam int CONV_SHIFT = 4;

	// weight[class][pooled_row*8 + col*2 + channel]
	// classes 0 and 1 share their channel 0 weights
	localparam weight_t DENSE_WEIGHT [cnn_shape_pkg::NUM_CLASSES][cnn_shape_pkg::DENSE_IN] = '{
		'{8'sd2, 8'sd1, -8'sd1, 8'sd3, 8'sd1, -8'sd2, 8'sd2, 8'sd1,
		  -8'sd1, 8'sd2, 8'sd3, -8'sd1, 8'sd2, 8'sd1, -8'sd2, 8'sd2,
		  8'sd1, -8'sd3, 8'sd2, 8'sd2, -8'sd1, 8'sd1, 8'sd3, -8'sd1,
		  8'sd2, 8'sd1, 8'sd1, -8'sd2, 8'sd3, 8'sd2, -8'sd1, 8'sd1},
		'{8'sd2, -8'sd1, -8'sd1, 8'sd2, 8'sd1, 8'sd3, 8'sd2, -8'sd2,
		  -8'sd1, 8'sd1, 8'sd3, 8'sd2, 8'sd2, -8'sd2, -8'sd2, 8'sd1,
		  8'sd1, 8'sd2, 8'sd2, -8'sd1, -8'sd1, 8'sd3, 8'sd3, 8'sd2,
		  8'sd2, -8'sd2, 8'sd1, 8'sd1, 8'sd3, -8'sd1, -8'sd1, 8'sd2},
		'{-8'sd2, 8'sd2, 8'sd1, 8'sd1, -8'sd1, 8'sd2, 8'sd1, 8'sd3,
		  8'sd1, -8'sd1, 8'sd2, 8'sd3, -8'sd2, 8'sd2, 8'sd1, -8'sd1,
		  8'sd3, 8'sd1, -8'sd1, 8'sd2, 8'sd2, -8'sd2, 8'sd1, 8'sd1,
		  -8'sd1, 8'sd3, 8'sd2, -8'sd1, 8'sd1, 8'sd2, 8'sd2, -8'sd2}
	};

	localparam cnn_shape_pkg::score_t DENSE_BIAS [cnn_shape_pkg::NUM_CLASSES] = '{
		20'sd100, 20'sd100, 20'sd60
	};

endpackage

//--- hdl/line_3_buffer.sv
module line_3_buffer (
	input  logic                      clk,
	input  logic                      resetn,
	input  cnn_shape_pkg::pixel_row_t row_i,
	input  logic                      row_valid_i,
	output cnn_shape_pkg::window_t    window_o,
	output logic                      window_valid_o
);

	// last two rows taken, prev1_q is the newest
	cnn_shape_pkg::pixel_row_t prev1_q;
	cnn_shape_pkg::pixel_row_t prev2_q;
	cnn_shape_pkg::row_idx_t row_cnt;
	// set after the last row, emits the bottom-padded window
	logic tail_pending;

	function automatic cnn_shape_pkg::padded_row_t pad_row(input cnn_shape_pkg::pixel_row_t r);
		return {cnn_shape_pkg::pixel_t'(0), r, cnn_shape_pkg::pixel_t'(0)};
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_cnt <= '0;
			tail_pending <= 1'b0;
			window_valid_o <= 1'b0;
		end else begin
			window_valid_o <= 1'b0;
			tail_pending <= 1'b0;
			if (tail_pending) begin
				window_valid_o <= 1'b1;
			end
			if (row_valid_i) begin
				// row 0 only fills the buffer
				if (row_cnt != '0) begin
					window_valid_o <= 1'b1;
				end
				if (row_cnt == cnn_shape_pkg::row_idx_t'(cnn_shape_pkg::IMG_H - 1)) begin
					row_cnt <= '0;
					tail_pending <= 1'b1;
				end else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
		end
	end

	// window payload and row history
	always_ff @(posedge clk) begin
		if (tail_pending) begin
			window_o.top <= pad_row(prev2_q);
			window_o.mid <= pad_row(prev1_q);
			window_o.bot <= '0;
		end else if (row_valid_i) begin
			// window centered on row 0 gets the zero top row
			if (row_cnt == cnn_shape_pkg::row_idx_t'(1)) begin
				window_o.top <= '0;
			end else begin
				window_o.top <= pad_row(prev2_q);
			end
			window_o.mid <= pad_row(prev1_q);
			window_o.bot <= pad_row(row_i);
		end
		if (row_valid_i) begin
			prev2_q <= prev1_q;
			prev1_q <= row_i;
		end
	end

endmodule

//--- hdl/conv_relu_row.sv
module conv_relu_row (
	input  logic                      clk,
	input  logic                      resetn,
	input  cnn_shape_pkg::window_t    window_i,
	input  logic                      window_valid_i,
	output cnn_shape_pkg::conv_row_t  row_o,
	output logic                      row_valid_o
);

	cnn_shape_pkg::padded_row_t win_rows [cnn_shape_pkg::KSIZE];
	cnn_shape_pkg::conv_row_t row_d;

	// relu and saturation in one clamp
	function automatic cnn_shape_pkg::feature_t clamp_feature(
		input cnn_shape_pkg::conv_sum_t v
	);
		if (v < 0) begin
			return '0;
		end
		if (v > cnn_shape_pkg::conv_sum_t'(cnn_shape_pkg::FEATURE_MAX)) begin
			return '1;
		end
		return cnn_shape_pkg::feature_t'(v);
	endfunction

	assign win_rows[0] = window_i.top;
	assign win_rows[1] = window_i.mid;
	assign win_rows[2] = window_i.bot;

	// output column c reads padded columns c..c+2
	always_comb begin
		cnn_shape_pkg::conv_sum_t acc;
		cnn_shape_pkg::conv_sum_t pix;
		cnn_shape_pkg::conv_sum_t coef;
		row_d = '0;
		for (int c = 0; c < cnn_shape_pkg::IMG_W; c++) begin
			for (int k = 0; k < cnn_shape_pkg::CONV_CH; k++) begin
				acc = cnn_shape_pkg::conv_sum_t'(cnn_weight_pkg::CONV_BIAS[k]);
				for (int dy = 0; dy < cnn_shape_pkg::KSIZE; dy++) begin
					for (int dx = 0; dx < cnn_shape_pkg::KSIZE; dx++) begin
						pix = cnn_shape_pkg::conv_sum_t'(
							win_rows[dy][(c + dx)*cnn_shape_pkg::PIXEL_W +: cnn_shape_pkg::PIXEL_W]);
						coef = cnn_shape_pkg::conv_sum_t'(cnn_weight_pkg::CONV_KERNEL[k][dy][dx]);
						acc = acc + pix * coef;
					end
				end
				// arithmetic shift keeps negative sums negative
				row_d[(c*cnn_shape_pkg::CONV_CH + k)*cnn_shape_pkg::PIXEL_W +: cnn_shape_pkg::PIXEL_W] =
					clamp_feature(acc >>> cnn_weight_pkg::CONV_SHIFT);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_valid_o <= 1'b0;
		end else begin
			row_valid_o <= window_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (window_valid_i) begin
			row_o <= row_d;
		end
	end

endmodule

//--- hdl/max_pool_row.sv
module max_pool_row (
	input  logic                      clk,
	input  logic                      resetn,
	input  cnn_shape_pkg::conv_row_t  row_i,
	input  logic                      row_valid_i,
	output cnn_shape_pkg::pool_row_t  row_o,
	output logic                      row_valid_o
);

	// low while waiting for an even row
	logic odd_row;
	cnn_shape_pkg::conv_row_t even_q;
	cnn_shape_pkg::pool_row_t pool_d;

	function automatic cnn_shape_pkg::feature_t max2(
		input cnn_shape_pkg::feature_t a,
		input cnn_shape_pkg::feature_t b
	);
		return (a > b) ? a : b;
	endfunction

	// 2x2 block is columns 2p and 2p+1 of the held and current rows
	always_comb begin
		int lo;
		int hi;
		pool_d = '0;
		for (int p = 0; p < cnn_shape_pkg::POOL_W; p++) begin
			for (int k = 0; k < cnn_shape_pkg::CONV_CH; k++) begin
				lo = ((2*p)*cnn_shape_pkg::CONV_CH + k)*cnn_shape_pkg::PIXEL_W;
				hi = ((2*p + 1)*cnn_shape_pkg::CONV_CH + k)*cnn_shape_pkg::PIXEL_W;
				pool_d[(p*cnn_shape_pkg::CONV_CH + k)*cnn_shape_pkg::PIXEL_W +: cnn_shape_pkg::PIXEL_W] =
					max2(max2(even_q[lo +: cnn_shape_pkg::PIXEL_W], even_q[hi +: cnn_shape_pkg::PIXEL_W]),
						max2(row_i[lo +: cnn_shape_pkg::PIXEL_W], row_i[hi +: cnn_shape_pkg::PIXEL_W]));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			odd_row <= 1'b0;
			row_valid_o <= 1'b0;
		end else begin
			row_valid_o <= row_valid_i && odd_row;
			if (row_valid_i) begin
				odd_row <= !odd_row;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid_i && !odd_row) begin
			even_q <= row_i;
		end
		if (row_valid_i && odd_row) begin
			row_o <= pool_d;
		end
	end

endmodule

//--- hdl/dense_classifier.sv
module dense_classifier (
	input  logic                        clk,
	input  logic                        resetn,
	input  cnn_shape_pkg::pool_row_t    row_i,
	input  logic                        row_valid_i,
	output cnn_shape_pkg::cnn_result_t  result_o,
	output logic                        result_valid_o
);

	cnn_shape_pkg::dense_state_t state;
	// index of the next pooled row, selects its weight slice
	cnn_shape_pkg::pool_idx_t row_cnt;
	cnn_shape_pkg::score_t acc [cnn_shape_pkg::NUM_CLASSES];
	cnn_shape_pkg::score_t next_acc [cnn_shape_pkg::NUM_CLASSES];
	cnn_shape_pkg::scores_t scores_d;
	cnn_shape_pkg::class_t best_idx;

	// first row starts from the biases
	always_comb begin
		cnn_shape_pkg::score_t feat;
		cnn_shape_pkg::score_t wgt;
		for (int j = 0; j < cnn_shape_pkg::NUM_CLASSES; j++) begin
			if (state == cnn_shape_pkg::IDLE) begin
				next_acc[j] = cnn_weight_pkg::DENSE_BIAS[j];
			end else begin
				next_acc[j] = acc[j];
			end
			for (int f = 0; f < cnn_shape_pkg::FEAT_PER_ROW; f++) begin
				feat = cnn_shape_pkg::score_t'(
					row_i[f*cnn_shape_pkg::PIXEL_W +: cnn_shape_pkg::PIXEL_W]);
				wgt = cnn_shape_pkg::score_t'(
					cnn_weight_pkg::DENSE_WEIGHT[j][int'(row_cnt)*cnn_shape_pkg::FEAT_PER_ROW + f]);
				next_acc[j] = next_acc[j] + feat * wgt;
			end
		end
	end

	// strict compare, so a tie keeps the lower class index
	always_comb begin
		cnn_shape_pkg::score_t best;
		best = acc[0];
		best_idx = '0;
		for (int j = 1; j < cnn_shape_pkg::NUM_CLASSES; j++) begin
			if (acc[j] > best) begin
				best = acc[j];
				best_idx = cnn_shape_pkg::class_t'(j);
			end
		end
		for (int j = 0; j < cnn_shape_pkg::NUM_CLASSES; j++) begin
			scores_d[j*cnn_shape_pkg::SCORE_W +: cnn_shape_pkg::SCORE_W] = acc[j];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= cnn_shape_pkg::IDLE;
			row_cnt <= '0;
			result_o <= '0;
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= 1'b0;
			case (state)
				cnn_shape_pkg::IDLE: begin
					if (row_valid_i) begin
						state <= cnn_shape_pkg::ACCUM;
						row_cnt <= row_cnt + 1'b1;
					end
				end
				cnn_shape_pkg::ACCUM: begin
					if (row_valid_i) begin
						if (row_cnt == cnn_shape_pkg::pool_idx_t'(cnn_shape_pkg::POOL_ROWS - 1)) begin
							state <= cnn_shape_pkg::DECIDE;
							row_cnt <= '0;
						end else begin
							row_cnt <= row_cnt + 1'b1;
						end
					end
				end
				cnn_shape_pkg::DECIDE: begin
					result_o.class_idx <= best_idx;
					result_o.scores <= scores_d;
					result_valid_o <= 1'b1;
					state <= cnn_shape_pkg::IDLE;
				end
				default: begin
					state <= cnn_shape_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid_i && state != cnn_shape_pkg::DECIDE) begin
			acc <= next_acc;
		end
	end

endmodule

//--- hdl/cnn_top.sv
module cnn_top (
	input  logic                        clk,
	input  logic                        resetn,
	input  cnn_shape_pkg::pixel_row_t   row_i,
	input  logic                        row_valid_i,
	output cnn_shape_pkg::cnn_result_t  result_o,
	output logic                        result_valid_o
);

	cnn_shape_pkg::window_t window;
	logic window_valid;
	cnn_shape_pkg::conv_row_t conv_row;
	logic conv_row_valid;
	cnn_shape_pkg::pool_row_t pool_row;
	logic pool_row_valid;

	line_3_buffer u_line_3_buffer (
		.clk            (clk),
		.resetn         (resetn),
		.row_i          (row_i),
		.row_valid_i    (row_valid_i),
		.window_o       (window),
		.window_valid_o (window_valid)
	);

	conv_relu_row u_conv_relu_row (
		.clk            (clk),
		.resetn         (resetn),
		.window_i       (window),
		.window_valid_i (window_valid),
		.row_o          (conv_row),
		.row_valid_o    (conv_row_valid)
	);

	// one pooled row per pair of conv rows
	max_pool_row u_max_pool_row (
		.clk         (clk),
		.resetn      (resetn),
		.row_i       (conv_row),
		.row_valid_i (conv_row_valid),
		.row_o       (pool_row),
		.row_valid_o (pool_row_valid)
	);

	dense_classifier u_dense_classifier (
		.clk            (clk),
		.resetn         (resetn),
		.row_i          (pool_row),
		.row_valid_i    (pool_row_valid),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

endmodule

//--- verification/cnn_clock_gen.sv
module cnn_clock_gen (
	output logic clk_o,
	output logic resetn_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 8;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// reset released on a rising edge after 8 cycles
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		resetn_o <= 1'b1;
	end

endmodule

//--- verification/cnn_tb.sv
module cnn_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_IMAGES = 20;
	localparam int TIE_IMAGES = 3;
	// zero, all-255, random, tie, the cut image and the one after the reset
	localparam int NUM_IMAGES = 2 + RANDOM_IMAGES + TIE_IMAGES + 2;
	localparam int LATENCY = 6;
	localparam int WATCHDOG_CYCLES =
		NUM_IMAGES * (cnn_shape_pkg::IMG_H * 4 + 10) + 2 * RESET_CYCLES;
	localparam int ROW_BITS = cnn_shape_pkg::IMG_W * cnn_shape_pkg::PIXEL_W;
	localparam int PW = cnn_shape_pkg::PIXEL_W;

	// row r at [r*ROW_BITS +: ROW_BITS] in the same pixel order as row_i
	typedef logic [cnn_shape_pkg::IMG_H*ROW_BITS-1:0] image_t;

	logic clk;
	logic gen_resetn;
	logic tb_resetn;
	logic resetn;
	cnn_shape_pkg::pixel_row_t row_i;
	logic row_valid_i;
	cnn_shape_pkg::cnn_result_t result_o;
	logic result_valid_o;

	// images waiting for their result and the time of their last row
	image_t img_q [$];
	time last_row_q [$];
	integer seed;
	image_t img;

	assign resetn = gen_resetn & tb_resetn;

	cnn_clock_gen u_clock_gen (
		.clk_o    (clk),
		.resetn_o (gen_resetn)
	);

	cnn_top u_dut (
		.clk            (clk),
		.resetn         (resetn),
		.row_i          (row_i),
		.row_valid_i    (row_valid_i),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

	// zero-padded conv, shift, clamp, 2x2 max pool and dense layer
	function automatic cnn_shape_pkg::cnn_result_t cnn_ref_model(input image_t im);
		int pad [cnn_shape_pkg::IMG_H+2][cnn_shape_pkg::IMG_W+2];
		int feat [cnn_shape_pkg::IMG_H][cnn_shape_pkg::IMG_W][cnn_shape_pkg::CONV_CH];
		int score [cnn_shape_pkg::NUM_CLASSES];
		int sum;
		int pooled;
		int best;
		cnn_shape_pkg::cnn_result_t res;
		for (int r = 0; r < cnn_shape_pkg::IMG_H + 2; r++) begin
			for (int c = 0; c < cnn_shape_pkg::IMG_W + 2; c++) begin
				pad[r][c] = 0;
			end
		end
		for (int r = 0; r < cnn_shape_pkg::IMG_H; r++) begin
			for (int c = 0; c < cnn_shape_pkg::IMG_W; c++) begin
				pad[r+1][c+1] = int'(im[r*ROW_BITS + c*PW +: PW]);
			end
		end
		for (int r = 0; r < cnn_shape_pkg::IMG_H; r++) begin
			for (int c = 0; c < cnn_shape_pkg::IMG_W; c++) begin
				for (int k = 0; k < cnn_shape_pkg::CONV_CH; k++) begin
					sum = int'(cnn_weight_pkg::CONV_BIAS[k]);
					for (int dy = 0; dy < 3; dy++) begin
						for (int dx = 0; dx < 3; dx++) begin
							sum += int'(cnn_weight_pkg::CONV_KERNEL[k][dy][dx]) * pad[r+dy][c+dx];
						end
					end
					sum = sum >>> cnn_weight_pkg::CONV_SHIFT;
					feat[r][c][k] = (sum < 0) ? 0 : ((sum > 255) ? 255 : sum);
				end
			end
		end
		for (int j = 0; j < cnn_shape_pkg::NUM_CLASSES; j++) begin
			score[j] = int'(cnn_weight_pkg::DENSE_BIAS[j]);
		end
		for (int pr = 0; pr < cnn_shape_pkg::POOL_ROWS; pr++) begin
			for (int pc = 0; pc < cnn_shape_pkg::POOL_W; pc++) begin
				for (int k = 0; k < cnn_shape_pkg::CONV_CH; k++) begin
					// features are never negative so 0 is a safe start
					pooled = 0;
					for (int d = 0; d < 4; d++) begin
						if (feat[2*pr + d/2][2*pc + d%2][k] > pooled) begin
							pooled = feat[2*pr + d/2][2*pc + d%2][k];
						end
					end
					for (int j = 0; j < cnn_shape_pkg::NUM_CLASSES; j++) begin
						score[j] += pooled * int'(cnn_weight_pkg::DENSE_WEIGHT[j]
							[pr*cnn_shape_pkg::FEAT_PER_ROW + pc*cnn_shape_pkg::CONV_CH + k]);
					end
				end
			end
		end
		// lowest index wins a tie
		best = score[0];
		res.class_idx = '0;
		for (int j = 0; j < cnn_shape_pkg::NUM_CLASSES; j++) begin
			if (score[j] > best) begin
				best = score[j];
				res.class_idx = cnn_shape_pkg::class_t'(j);
			end
			res.scores[j*cnn_shape_pkg::SCORE_W +: cnn_shape_pkg::SCORE_W] =
				cnn_shape_pkg::score_t'(score[j]);
		end
		return res;
	endfunction

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_class(input cnn_shape_pkg::class_t exp_v,
		input cnn_shape_pkg::class_t act_v);
		if (act_v !== exp_v) begin
			$display("Fail at %0d ns: result_o.class_idx expected %0d, got %0d",
				$time, exp_v, act_v);
			stop_run();
		end
	endtask

	task automatic check_scores(input cnn_shape_pkg::scores_t exp_v,
		input cnn_shape_pkg::scores_t act_v);
		if (act_v !== exp_v) begin
			$display("Fail at %0d ns: result_o.scores expected %h, got %h", $time, exp_v, act_v);
			stop_run();
		end
	endtask

	task automatic check_latency(input int exp_v, input int act_v);
		if (act_v != exp_v) begin
			$display("Fail at %0d ns: result_valid_o latency expected %0d cycles, got %0d",
				$time, exp_v, act_v);
			stop_run();
		end
	endtask

	task automatic random_image(input cnn_shape_pkg::pixel_t mask);
		for (int i = 0; i < cnn_shape_pkg::IMG_H * cnn_shape_pkg::IMG_W; i++) begin
			img[i*PW +: PW] = cnn_shape_pkg::pixel_t'($random(seed)) & mask;
		end
	endtask

	// rows gets less than IMG_H for an image cut off by reset
	task automatic send_image(input image_t im, input int gap_max, input int rows);
		int gap;
		for (int r = 0; r < rows; r++) begin
			@(posedge clk);
			row_i <= im[r*ROW_BITS +: ROW_BITS];
			row_valid_i <= 1'b1;
			gap = 0;
			if (r < rows - 1 && gap_max > 0) begin
				gap = int'($unsigned($random(seed)) % (gap_max + 1));
			end
			if (gap > 0) begin
				@(posedge clk);
				row_valid_i <= 1'b0;
				repeat (gap - 1) @(posedge clk);
			end
		end
		if (rows == cnn_shape_pkg::IMG_H) begin
			img_q.push_back(im);
			last_row_q.push_back($time);
		end
		// two idle cycles before the next image
		@(posedge clk);
		row_valid_i <= 1'b0;
		@(posedge clk);
	endtask

	initial begin
		cnn_shape_pkg::cnn_result_t tie_res;
		cnn_shape_pkg::score_t tie_s0;
		cnn_shape_pkg::score_t tie_s1;
		cnn_shape_pkg::score_t tie_s2;
		seed = 5240;
		row_i = '0;
		row_valid_i = 1'b0;
		tb_resetn = 1'b1;
		wait (gen_resetn === 1'b1);
		img = '0;
		send_image(img, 0, cnn_shape_pkg::IMG_H);
		img = '1;
		send_image(img, 0, cnn_shape_pkg::IMG_H);
		repeat (RANDOM_IMAGES) begin
			random_image(8'hff);
			send_image(img, 3, cnn_shape_pkg::IMG_H);
		end
		// pixels up to 3 keep channel 1 at zero so classes 0 and 1 score alike
		repeat (TIE_IMAGES) begin
			random_image(8'h03);
			tie_res = cnn_ref_model(img);
			tie_s0 = tie_res.scores[0 +: cnn_shape_pkg::SCORE_W];
			tie_s1 = tie_res.scores[cnn_shape_pkg::SCORE_W +: cnn_shape_pkg::SCORE_W];
			tie_s2 = tie_res.scores[2*cnn_shape_pkg::SCORE_W +: cnn_shape_pkg::SCORE_W];
			// class 2 has to stay below the tie for the tie rule to decide
			if (tie_s0 !== tie_s1 || tie_s2 >= tie_s0) begin
				$display("crafted tie image does not tie the two highest scores");
				stop_run();
			end
			send_image(img, 0, cnn_shape_pkg::IMG_H);
		end
		while (img_q.size() != 0) begin
			@(posedge clk);
		end
		// reset lands in the middle of an image
		random_image(8'hff);
		send_image(img, 1, 5);
		tb_resetn <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		tb_resetn <= 1'b1;
		random_image(8'hff);
		send_image(img, 2, cnn_shape_pkg::IMG_H);
		repeat (LATENCY + 4) @(posedge clk);
		if (img_q.size() != 0) begin
			$display("%0d images never produced a result", img_q.size());
			stop_run();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

	// outputs settle after the rising edge so compare on the falling one
	always @(negedge clk) begin : compare_results
		cnn_shape_pkg::cnn_result_t exp_res;
		time t_last;
		if (!resetn) begin
			if (result_valid_o === 1'b1) begin
				$display("result_valid_o was not low while reset was asserted");
				stop_run();
			end
		end else if (result_valid_o === 1'b1) begin
			if (img_q.size() == 0) begin
				$display("result_valid_o pulsed with no image waiting for a result");
				stop_run();
			end else begin
				exp_res = cnn_ref_model(img_q.pop_front());
				t_last = last_row_q.pop_front();
				check_latency(LATENCY, int'(($time - t_last) / CLK_PERIOD));
				check_class(exp_res.class_idx, result_o.class_idx);
				check_scores(exp_res.scores, result_o.scores);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles without finishing the test", WATCHDOG_CYCLES);
		stop_run();
	end

endmodule

//--- list.f
hdl/cnn_shape_pkg.sv
hdl/cnn_weight_pkg.sv
hdl/line_3_buffer.sv
hdl/conv_relu_row.sv
hdl/max_pool_row.sv
hdl/dense_classifier.sv
hdl/cnn_top.sv
verification/cnn_clock_gen.sv
verification/cnn_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module cnn_tb --Mdir obj_dir -o cnn_sim

# the simulator exits non-zero on a fatal error, the log decides
./obj_dir/cnn_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
